/* rtl/spiClkDiv.sv */
`timescale 1ns/1ps
`include "spiLink_defs.svh"

module spiClkDiv
(
	input  logic iSysClk,
	input  logic arstN,
	output logic divCke
);

	// Counter width, at least one bit
	localparam int cntW = (`SPI_DIV_RATIO > 1) ? $clog2(`SPI_DIV_RATIO) : 1;
	localparam logic [cntW-1:0] cntLast = cntW'(`SPI_DIV_RATIO - 1);

	logic [cntW-1:0] divCnt;

	// Free-running modulo counter
	// One-cycle enable at each wrap
	always_ff @(posedge iSysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			divCnt <= '0;
			divCke <= 1'b0;
		end
		else
		begin
			if (divCnt == cntLast)
				divCnt <= '0;
			else
				divCnt <= divCnt + 1'b1;
			divCke <= (divCnt == cntLast);
		end
	end

endmodule

/* rtl/spiLink.sv */
`timescale 1ns/1ps
`include "spiLink_defs.svh"

module spiLink
(
	input  logic                      iSysClk,
	input  logic                      arstN,
	// Pins
	input  logic                      msSel,
	input  logic                      sckIn,
	output logic                      sckOut,
	output logic                      sckOe,
	input  logic                      mosiIn,
	output logic                      mosiOut,
	output logic                      mosiOe,
	input  logic                      misoIn,
	output logic                      misoOut,
	output logic                      misoOe,
	input  logic                      csNIn,
	output logic                      csNOut,
	output logic                      csNOe,
	output logic                      roleSlave,
	// Slave side
	input  logic [`SPI_WORD_BITS-1:0] txWord,
	output logic [`SPI_WORD_BITS-1:0] rxWord,
	output logic [`SPI_WORD_BITS-1:0] addr,
	output spiLinkPkg::spiCmdT        cmd,
	output logic [15:0]               dataLen,
	output logic                      wordValid,
	// Master side
	input  logic                      spiEn,
	input  logic                      csNMaster,
	input  logic [`SPI_BYTE_BITS-1:0] txByte,
	output logic [`SPI_BYTE_BITS-1:0] rxByte,
	output logic                      byteDone
);

	logic divCke;

	// One bundle per role
	spiWireIf slvWire();
	spiWireIf mstWire();

	spiClkDiv clkDiv_i
	(
		.iSysClk (iSysClk),
		.arstN   (arstN),
		.divCke  (divCke)
	);

	spiPinMux pinMux_i
	(
		.iSysClk   (iSysClk),
		.arstN     (arstN),
		.msSel     (msSel),
		.sckIn     (sckIn),
		.sckOut    (sckOut),
		.sckOe     (sckOe),
		.mosiIn    (mosiIn),
		.mosiOut   (mosiOut),
		.mosiOe    (mosiOe),
		.misoIn    (misoIn),
		.misoOut   (misoOut),
		.misoOe    (misoOe),
		.csNIn     (csNIn),
		.csNOut    (csNOut),
		.csNOe     (csNOe),
		.csNMaster (csNMaster),
		.slv       (slvWire.pins),
		.mst       (mstWire.pins),
		.roleSlave (roleSlave)
	);

	spiSlaveFrame slaveFrame_i
	(
		.iSysClk   (iSysClk),
		.arstN     (arstN),
		.bus       (slvWire.slave),
		.txWord    (txWord),
		.rxWord    (rxWord),
		.addr      (addr),
		.cmd       (cmd),
		.dataLen   (dataLen),
		.wordValid (wordValid)
	);

	spiMasterByte masterByte_i
	(
		.iSysClk  (iSysClk),
		.arstN    (arstN),
		.spiEn    (spiEn),
		.divCke   (divCke),
		.txByte   (txByte),
		.rxByte   (rxByte),
		.byteDone (byteDone),
		.bus      (mstWire.master)
	);

endmodule

/* rtl/spiLinkPkg.sv */
`include "spiLink_defs.svh"

package spiLinkPkg;

	// Phase of a slave frame
	typedef enum logic [1:0]
	{
		stAddr = 2'd0,
		stCmd  = 2'd1,
		stData = 2'd2
	} slaveStateT;

	// Command field of the header word
	typedef enum logic [2:0]
	{
		cmdNone  = 3'd0,
		cmdRegWr = 3'd1,
		cmdRegRd = 3'd2,
		cmdMemWr = 3'd3,
		cmdMemRd = 3'd4
	} spiCmdT;

	// Slave shift register, read raw or as a command word
	typedef union packed
	{
		logic [`SPI_WORD_BITS-1:0] raw;
		struct packed
		{
			logic [12:0] rsvd;
			spiCmdT      cmd;
			logic [15:0] len;
		} hdr;
	} hdrWordT;

endpackage

/* rtl/spiLink_defs.svh */
`ifndef SPILINK_DEFS_SVH
`define SPILINK_DEFS_SVH

// --------------------------------------------------
// Master role timing
// --------------------------------------------------

// System clocks per half SCK period
`define SPI_DIV_RATIO 4

// System clocks MOSI waits after an SCK fall
`define SPI_HOLD_CYCLES 2

// --------------------------------------------------
// Slave role and data widths
// --------------------------------------------------

// Flip-flop stages on every incoming pin
`define SPI_SYNC_DEPTH 3

// Slave word and master byte widths
`define SPI_WORD_BITS 32
`define SPI_BYTE_BITS 8

`endif

/* rtl/spiMasterByte.sv */
`timescale 1ns/1ps
`include "spiLink_defs.svh"

module spiMasterByte
(
	input  logic                      iSysClk,
	input  logic                      arstN,
	input  logic                      spiEn,
	input  logic                      divCke,
	input  logic [`SPI_BYTE_BITS-1:0] txByte,
	output logic [`SPI_BYTE_BITS-1:0] rxByte,
	output logic                      byteDone,
	spiWireIf.master                  bus
);

	localparam int byteW   = `SPI_BYTE_BITS;
	localparam int bitCntW = $clog2(`SPI_BYTE_BITS);
	localparam int holdW   = $clog2(`SPI_HOLD_CYCLES + 1);

	logic               sck;
	logic               sckFallNow;
	logic               lastFall;
	logic [bitCntW-1:0] fallCnt;
	logic               holdActive;
	logic [holdW-1:0]   holdCnt;
	logic               holdDone;
	logic [byteW-1:0]   txSh;

	// SCK about to drop this cycle
	assign sckFallNow = spiEn && divCke && sck;
	assign lastFall   = sckFallNow && (fallCnt == bitCntW'(byteW - 1));
	// MOSI moves SPI_HOLD_CYCLES after SCK is low
	assign holdDone   = holdActive && (holdCnt == holdW'(`SPI_HOLD_CYCLES - 1));

	// --------------------------------------------------
	// SCK, fall count, hold timer
	// --------------------------------------------------

	always_ff @(posedge iSysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			sck        <= 1'b0;
			fallCnt    <= '0;
			holdActive <= 1'b0;
			holdCnt    <= '0;
			byteDone   <= 1'b0;
		end
		else
		begin
			// Mode 0, idles low
			if (!spiEn)
				sck <= 1'b0;
			else if (divCke)
				sck <= !sck;

			if (!spiEn)
				fallCnt <= '0;
			else if (sckFallNow)
				fallCnt <= fallCnt + 1'b1;

			// Idle until a fall, active until hold expires
			if (!spiEn)
				holdActive <= 1'b0;
			else if (sckFallNow)
				holdActive <= 1'b1;
			else if (holdDone)
				holdActive <= 1'b0;

			if (!holdActive || holdDone)
				holdCnt <= '0;
			else
				holdCnt <= holdCnt + 1'b1;

			// Eighth fall closes the byte
			byteDone <= lastFall;
		end
	end

	// --------------------------------------------------
	// Data shifters
	// --------------------------------------------------

	always_ff @(posedge iSysClk)
	begin
		// Reload while disabled, shift after each hold
		if (!spiEn)
			txSh <= txByte;
		else if (holdDone)
			txSh <= {txSh[byteW-2:0], 1'b1};

		// MISO in as SCK rises
		if (spiEn && divCke && !sck)
			rxByte <= {rxByte[byteW-2:0], bus.miso};
	end

	assign bus.sck  = sck;
	assign bus.mosi = txSh[byteW-1];

	aDonePulse: assert property (@(posedge iSysClk) disable iff (!arstN)
		byteDone |=> !byteDone)
		else $error("Byte completion held longer than one cycle");

endmodule

/* rtl/spiPinMux.sv */
`timescale 1ns/1ps
`include "spiLink_defs.svh"

module spiPinMux
(
	input  logic   iSysClk,
	input  logic   arstN,
	input  logic   msSel,
	input  logic   sckIn,
	output logic   sckOut,
	output logic   sckOe,
	input  logic   mosiIn,
	output logic   mosiOut,
	output logic   mosiOe,
	input  logic   misoIn,
	output logic   misoOut,
	output logic   misoOe,
	input  logic   csNIn,
	output logic   csNOut,
	output logic   csNOe,
	input  logic   csNMaster,
	spiWireIf.pins slv,
	spiWireIf.pins mst,
	output logic   roleSlave
);

	localparam int syncD = `SPI_SYNC_DEPTH;

	logic [syncD-1:0] selSh;

	// --------------------------------------------------
	// Role select synchronizer
	// --------------------------------------------------

	// Resets to all ones so the slave role comes up first
	always_ff @(posedge iSysClk or negedge arstN)
	begin
		if (!arstN)
			selSh <= '1;
		else
			selSh <= {selSh[syncD-2:0], msSel};
	end

	assign roleSlave = selSh[syncD-1];

	// --------------------------------------------------
	// Pin direction and routing
	// --------------------------------------------------

	// Slave role drives only MISO and the master role drives the rest
	assign sckOe  = !roleSlave;
	assign mosiOe = !roleSlave;
	assign csNOe  = !roleSlave;
	assign misoOe = roleSlave;

	// Slave view held deselected while mastering
	assign slv.sck  = sckIn;
	assign slv.mosi = mosiIn;
	assign slv.csN  = roleSlave ? csNIn : 1'b1;
	assign misoOut  = slv.miso;

	// Master view with chip select on the same bundle
	assign mst.miso = misoIn;
	assign mst.csN  = csNMaster;
	assign sckOut   = mst.sck;
	assign mosiOut  = mst.mosi;
	assign csNOut   = mst.csN;

endmodule

/* rtl/spiSlaveFrame.sv */
`timescale 1ns/1ps
`include "spiLink_defs.svh"

module spiSlaveFrame
(
	input  logic                      iSysClk,
	input  logic                      arstN,
	spiWireIf.slave                   bus,
	input  logic [`SPI_WORD_BITS-1:0] txWord,
	output logic [`SPI_WORD_BITS-1:0] rxWord,
	output logic [`SPI_WORD_BITS-1:0] addr,
	output spiLinkPkg::spiCmdT        cmd,
	output logic [15:0]               dataLen,
	output logic                      wordValid
);

	localparam int syncD = `SPI_SYNC_DEPTH;
	localparam int wordW = `SPI_WORD_BITS;
	localparam int cntW  = $clog2(`SPI_WORD_BITS);

	logic [syncD-1:0]       sckSh;
	logic [syncD-1:0]       mosiSh;
	logic [syncD-1:0]       csSh;
	logic                   csHigh;
	logic                   sckRise;
	logic                   sckFall;
	logic                   wordEnd;
	logic                   mosiBit;
	logic [cntW-1:0]        fallCnt;
	spiLinkPkg::slaveStateT state;
	spiLinkPkg::hdrWordT    rxSh;
	logic [wordW-1:0]       txSh;

	// --------------------------------------------------
	// Input synchronizers and edge detect
	// --------------------------------------------------

	// Chip select idles high
	always_ff @(posedge iSysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			sckSh  <= '0;
			mosiSh <= '0;
			csSh   <= '1;
		end
		else
		begin
			sckSh  <= {sckSh[syncD-2:0], bus.sck};
			mosiSh <= {mosiSh[syncD-2:0], bus.mosi};
			csSh   <= {csSh[syncD-2:0], bus.csN};
		end
	end

	assign csHigh  = csSh[syncD-1];
	// Two stable samples after the old level
	assign sckRise = !csHigh && (sckSh[syncD-1 -: 3] == 3'b011);
	assign sckFall = !csHigh && (sckSh[syncD-1 -: 3] == 3'b100);
	// Oldest MOSI sample has settled since the last fall
	assign mosiBit = mosiSh[syncD-1];
	// After 31 falls the next one ends the word
	assign wordEnd = (fallCnt == cntW'(wordW - 1));

	// --------------------------------------------------
	// Frame FSM and header fields
	// --------------------------------------------------

	always_ff @(posedge iSysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			state     <= spiLinkPkg::stAddr;
			fallCnt   <= '0;
			addr      <= '0;
			cmd       <= spiLinkPkg::cmdNone;
			dataLen   <= '0;
			wordValid <= 1'b0;
		end
		else
		begin
			// Address and command words then data until deselect
			if (csHigh)
				state <= spiLinkPkg::stAddr;
			else if (sckFall && wordEnd && state == spiLinkPkg::stAddr)
				state <= spiLinkPkg::stCmd;
			else if (sckFall && wordEnd && state == spiLinkPkg::stCmd)
				state <= spiLinkPkg::stData;

			// Bit count wraps every word
			if (csHigh)
				fallCnt <= '0;
			else if (sckFall)
				fallCnt <= fallCnt + 1'b1;

			// Start address plus one step per data word
			if (sckFall && wordEnd && state == spiLinkPkg::stAddr)
				addr <= rxSh.raw;
			else if (sckFall && wordEnd && state == spiLinkPkg::stData)
				addr <= addr + 1'b1;

			// Command word decode
			if (csHigh)
			begin
				cmd     <= spiLinkPkg::cmdNone;
				dataLen <= '0;
			end
			else if (sckFall && wordEnd && state == spiLinkPkg::stCmd)
			begin
				cmd     <= rxSh.hdr.cmd;
				dataLen <= rxSh.hdr.len;
			end

			wordValid <= sckRise && wordEnd && (state == spiLinkPkg::stData);
		end
	end

	// --------------------------------------------------
	// Receive and reply shifters
	// --------------------------------------------------

	always_ff @(posedge iSysClk)
	begin
		// MOSI in on rising SCK
		if (sckRise)
			rxSh.raw <= {rxSh.raw[wordW-2:0], mosiBit};
		if (sckRise && wordEnd && state == spiLinkPkg::stData)
			rxWord <= {rxSh.raw[wordW-2:0], mosiBit};

		// Reply word held until the data phase with ones shifted in behind it
		if (state != spiLinkPkg::stData)
			txSh <= txWord;
		else if (sckFall)
			txSh <= {txSh[wordW-2:0], 1'b1};
	end

	assign bus.miso = txSh[wordW-1];

	aValidInData: assert property (@(posedge iSysClk) disable iff (!arstN)
		wordValid |-> state == spiLinkPkg::stData)
		else $error("Data word strobe outside the data phase");

	// Select pin high through the synchronizer leaves the header wiped
	aClearOnCs: assert property (@(posedge iSysClk) disable iff (!arstN)
		bus.csN [*syncD + 2] |-> (cmd == spiLinkPkg::cmdNone && dataLen == '0))
		else $error("Header fields kept after chip select rose");

endmodule

/* rtl/spiWireIf.sv */
`timescale 1ns/1ps

// Internal SPI line bundle, one instance per role
interface spiWireIf;

	// Mode 0 serial clock
	wire sck;
	wire mosi;
	wire miso;
	// Active-low chip select
	wire csN;

	// Slave role listens on clock, data in and select
	modport slave
	(
		input  sck,
		input  mosi,
		input  csN,
		output miso
	);

	// Master role drives clock and data out
	modport master
	(
		output sck,
		output mosi,
		input  miso
	);

	// Pin side, drives whichever lines face its role
	modport pins
	(
		inout sck,
		inout mosi,
		inout miso,
		inout csN
	);

endinterface

/* spiLink.f */
+incdir+rtl
rtl/spiLinkPkg.sv
rtl/spiWireIf.sv
rtl/spiClkDiv.sv
rtl/spiPinMux.sv
rtl/spiSlaveFrame.sv
rtl/spiMasterByte.sv
rtl/spiLink.sv
test/spiLinkTb.sv

/* test/spiLinkTb.sv */
`timescale 1ns/1ps
`include "spiLink_defs.svh"

module spiLinkTb;

	// Frames including the aborted one at worst-case bits each
	localparam int frameCount   = 4;
	localparam int frameBitsMax = 64 + 3 * `SPI_WORD_BITS;
	localparam int byteCount    = 3;
	localparam longint watchdogNs = frameCount * frameBitsMax * 600
		+ byteCount * `SPI_BYTE_BITS * 2 * `SPI_DIV_RATIO * 100 + 100000;

	logic iSysClk;
	logic arstN;
	logic msSel;
	logic sckIn;
	logic sckOut;
	logic sckOe;
	logic mosiIn;
	logic mosiOut;
	logic mosiOe;
	logic misoIn;
	logic misoOut;
	logic misoOe;
	logic csNIn;
	logic csNOut;
	logic csNOe;
	logic roleSlave;
	logic [31:0] txWord;
	logic [31:0] rxWord;
	logic [31:0] addr;
	spiLinkPkg::spiCmdT cmd;
	logic [15:0] dataLen;
	logic wordValid;
	logic spiEn;
	logic csNMaster;
	logic [7:0] txByte;
	logic [7:0] rxByte;
	logic byteDone;

	// Expected data word, strobe counts, MOSI capture
	logic [31:0] expWord = '0;
	int validCnt = 0;
	int doneCnt = 0;
	logic [7:0] mosiCap = '0;
	logic sckPrev = 1'b0;

	spiLink spiLink_i (.*);

	// External slave model loops MOSI straight back to MISO
	assign misoIn = mosiOut;

	initial iSysClk = 1'b0;
	always #50 iSysClk = !iSysClk;

	// --------------------------------------------------
	// Failure reporting and checks
	// --------------------------------------------------

	task automatic mismatchFatal(input string testName, input logic [31:0] expVal,
		input logic [31:0] actVal);
		$display("** Error [%s] expected %h actual %h", testName, expVal, actVal);
		$display("Checks failed");
		$fatal(1, "Stopped at first mismatch");
	endtask

	task automatic failureFatal(input string reason);
		$display("Failure: %s", reason);
		$display("Checks failed");
		$fatal(1, "Stopped on failure");
	endtask

	task automatic checkEq(input string testName, input logic [31:0] expVal,
		input logic [31:0] actVal);
		assert (actVal === expVal)
			else mismatchFatal(testName, expVal, actVal);
	endtask

	// Strobed data word must match the word just sent
	aRxWord: assert property (@(posedge iSysClk) disable iff (!arstN)
		wordValid |-> rxWord == expWord)
		else mismatchFatal("data word", expWord, rxWord);

	// Role and enables follow the select pin one synchronizer late
	aPinDir: assert property (@(posedge iSysClk) disable iff (!arstN)
		roleSlave == $past(msSel, `SPI_SYNC_DEPTH)
		&& misoOe == $past(msSel, `SPI_SYNC_DEPTH)
		&& sckOe == !$past(msSel, `SPI_SYNC_DEPTH)
		&& mosiOe == !$past(msSel, `SPI_SYNC_DEPTH)
		&& csNOe == !$past(msSel, `SPI_SYNC_DEPTH))
		else failureFatal("role or pin output enables do not follow the role select");

	always @(posedge iSysClk)
	begin
		if (wordValid)
			validCnt <= validCnt + 1;
		if (byteDone)
			doneCnt <= doneCnt + 1;
	end

	// MOSI as seen by a slave at each SCK rise
	always @(negedge iSysClk)
	begin
		if (sckOut && !sckPrev)
			mosiCap <= {mosiCap[6:0], mosiOut};
		sckPrev <= sckOut;
	end

	// --------------------------------------------------
	// External SPI master model, mode 0
	// --------------------------------------------------

	task automatic waitCycles(input int n);
		repeat (n) @(negedge iSysClk);
	endtask

	// 300 ns half period with MISO sampled as SCK rises
	task automatic shiftWord(input logic [31:0] word, input int nBits,
		output logic [31:0] misoWord);
		misoWord = '0;
		for (int i = 0; i < nBits; i++)
		begin
			mosiIn = word[31 - i];
			waitCycles(3);
			misoWord = {misoWord[30:0], misoOut};
			sckIn = 1'b1;
			waitCycles(3);
			sckIn = 1'b0;
		end
	endtask

	// Select and send the address and command words
	task automatic sendHeader(output logic [31:0] startAddr);
		logic [31:0] hdr;
		logic [31:0] misoWord;
		logic [2:0] cmdVal;
		logic [15:0] lenVal;
		startAddr = $urandom;
		cmdVal = 3'($urandom % 5);
		lenVal = 16'($urandom);
		hdr = {13'($urandom), cmdVal, lenVal};
		csNIn = 1'b0;
		waitCycles(4);
		shiftWord(startAddr, 32, misoWord);
		waitCycles(4);
		checkEq("header addr", startAddr, addr);
		shiftWord(hdr, 32, misoWord);
		waitCycles(4);
		checkEq("header cmd", 32'(cmdVal), 32'(cmd));
		checkEq("header length", 32'(lenVal), 32'(dataLen));
	endtask

	// Deselect wipes the decoded header
	task automatic closeFrame();
		csNIn = 1'b1;
		waitCycles(5);
		checkEq("cleared cmd", 32'd0, 32'(cmd));
		checkEq("cleared length", 32'd0, 32'(dataLen));
	endtask

	task automatic runFrame(input int nWords);
		logic [31:0] startAddr;
		logic [31:0] misoWord;
		int baseCnt;
		txWord = $urandom;
		sendHeader(startAddr);
		baseCnt = validCnt;
		for (int i = 0; i < nWords; i++)
		begin
			expWord = $urandom;
			shiftWord(expWord, 32, misoWord);
			waitCycles(4);
			checkEq("strobe count", 32'(baseCnt + i + 1), 32'(validCnt));
			checkEq("word addr", startAddr + 32'(i + 1), addr);
			// Reply word first and all ones after it
			if (i == 0)
				checkEq("reply word", txWord, misoWord);
			else
				checkEq("reply fill", 32'hffff_ffff, misoWord);
		end
		closeFrame();
	endtask

	// One byte in master role ending on byteDone
	task automatic runByte();
		int baseDone;
		txByte = 8'($urandom);
		csNMaster = 1'b0;
		waitCycles(1);
		checkEq("master select", 32'd0, 32'(csNOut));
		baseDone = doneCnt;
		spiEn = 1'b1;
		do
			@(negedge iSysClk);
		while (!byteDone);
		spiEn = 1'b0;
		csNMaster = 1'b1;
		waitCycles(4);
		checkEq("master deselect", 32'd1, 32'(csNOut));
		checkEq("master sck idle", 32'd0, 32'(sckOut));
		checkEq("master mosi", 32'(txByte), 32'(mosiCap));
		checkEq("master rx", 32'(txByte), 32'(rxByte));
		checkEq("master done count", 32'(baseDone + 1), 32'(doneCnt));
	endtask

	// --------------------------------------------------
	// Test sequence and watchdog
	// --------------------------------------------------

	initial
	begin
		logic [31:0] startAddr;
		logic [31:0] misoWord;
		int baseCnt;
		arstN = 1'b0;
		msSel = 1'b1;
		sckIn = 1'b0;
		mosiIn = 1'b0;
		csNIn = 1'b1;
		txWord = '0;
		spiEn = 1'b0;
		csNMaster = 1'b1;
		txByte = '0;
		void'($urandom(32'hbbb3_589c));
		waitCycles(4);
		arstN = 1'b1;
		waitCycles(2);
		checkEq("reset wordValid", 32'd0, 32'(wordValid));
		checkEq("reset byteDone", 32'd0, 32'(byteDone));
		checkEq("reset roleSlave", 32'd1, 32'(roleSlave));

		runFrame(1);
		runFrame(3);

		// Abort in the middle of a data word
		txWord = $urandom;
		sendHeader(startAddr);
		baseCnt = validCnt;
		shiftWord($urandom, 10, misoWord);
		closeFrame();
		checkEq("abort strobe count", 32'(baseCnt), 32'(validCnt));
		runFrame(2);

		// Master role
		msSel = 1'b0;
		waitCycles(5);
		repeat (byteCount) runByte();

		$display("All checks passed");
		$finish;
	end

	initial
	begin
		#(watchdogNs);
		failureFatal("watchdog expired before the tests finished");
	end

endmodule
